// ==== files.f ====
scope_pkg.sv
scope_regs.sv
scope_dec_avg.sv
scope_edge.sv
scope_acq.sv
scope_top.sv
tb_scope_top.sv

// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vtb_scope_top
	./obj_dir/Vtb_scope_top | tee /dev/stderr | grep -q "^PASS: all tests$$"

obj_dir/Vtb_scope_top: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_scope_top -f files.f

clean:
	rm -rf obj_dir

// ==== tb_scope_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_scope_top;

  logic               clk = 1'b0;
  logic               rstn;
  logic signed [13:0] sti_dat, sto_dat;
  logic               sti_vld, sti_rdy, sto_lst, sto_vld, sto_rdy;
  logic         [3:0] trg_ext;
  logic               trg_swo;
  logic         [1:0] trg_out;
  logic        [31:0] sys_addr, sys_wdata, sys_rdata;
  logic               sys_wen, sys_ren, sys_ack, sys_err;

  int          val_errs, misc_errs, n_acc, p_cnt, n_cnt, swo_cnt, rdy_mode;
  // reference model state
  int          m_avg, m_dec, m_shr, m_lvl, m_hst, m_cnt, m_left, d;
  longint      m_sum, sh;
  bit          m_on, m_trg, ap, an, exp_p, exp_n, lst;
  logic [13:0] q_dat[$];
  bit          q_lst[$];
  logic [13:0] v;

  scope_top #(.DWI(14), .TWA(4)) scope_top_inst (
    .clk(clk), .rstn(rstn),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .sto_dat(sto_dat), .sto_lst(sto_lst), .sto_vld(sto_vld), .sto_rdy(sto_rdy),
    .trg_ext(trg_ext), .trg_swo(trg_swo), .trg_out(trg_out),
    .sys_addr(sys_addr), .sys_wdata(sys_wdata), .sys_wen(sys_wen), .sys_ren(sys_ren),
    .sys_rdata(sys_rdata), .sys_ack(sys_ack), .sys_err(sys_err)
  );

  always #2 clk = ~clk;  // 4 ns period

  always @(negedge clk) begin  // 0 ready, 1 random, 2 stalled
    sto_rdy = (rdy_mode == 0) || (rdy_mode == 1 && ($urandom % 3) != 0);
  end

  function automatic int sext14(input logic [31:0] x);
    return int'($signed(x[13:0]));
  endfunction

  task automatic fail_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("FAIL %s: got %h expected %h", name, got, exp);
    val_errs++;
  endtask

  task automatic finish_run();
    $display("errors: value %0d, other %0d", val_errs, misc_errs);
    if (val_errs == 0 && misc_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("timeout waiting for %s", what);
    misc_errs++;
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor with edge, decimator and acquisition model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      ap    = 0;
      an    = 0;
      exp_p = 0;
      exp_n = 0;
    end else begin
      if (trg_out[0] !== exp_p) fail_val("trg_out[0]", trg_out[0], exp_p);
      if (trg_out[1] !== exp_n) fail_val("trg_out[1]", trg_out[1], exp_n);
      p_cnt += trg_out[0];
      n_cnt += trg_out[1];
      swo_cnt += trg_swo;
      exp_p = 0;
      exp_n = 0;
      if (sti_vld && sti_rdy) begin
        n_acc++;
        d = int'(sti_dat);
        if (ap && d >= m_lvl) begin
          exp_p = 1;
          ap    = 0;
        end else if (d < m_lvl - m_hst) begin
          ap = 1;
        end
        if (an && d <= m_lvl) begin
          exp_n = 1;
          an    = 0;
        end else if (d > m_lvl + m_hst) begin
          an = 1;
        end
        m_sum = (m_cnt == 0) ? longint'(d) : m_sum + d;
        m_cnt++;
        if (m_cnt >= m_dec) begin  // dec-th sample closes the group, 0 and 1 pass all
          m_cnt = 0;
          sh    = m_sum >>> m_shr;
          v     = m_avg ? sh[13:0] : sti_dat;
          if (m_on) begin
            lst = m_trg && m_left == 0;
            q_dat.push_back(v);
            q_lst.push_back(lst);
            if (lst) begin
              m_on  = 0;
              m_trg = 0;
            end else if (m_trg) begin
              m_left--;
            end
          end
        end
      end
      if (sto_vld && sto_rdy) begin
        if (q_dat.size() == 0) begin
          $display("output sample %h arrived with none expected", sto_dat);
          misc_errs++;
        end else begin
          if (sto_dat !== q_dat[0]) fail_val("sto_dat", sto_dat, q_dat[0]);
          if (sto_lst !== q_lst[0]) fail_val("sto_lst", sto_lst, q_lst[0]);
          void'(q_dat.pop_front());
          void'(q_lst.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus and stream tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_ack();
    int t;
    t = 0;
    while (!sys_ack && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (!sys_ack) timed_out("bus ack");
  endtask

  task automatic bus_write(input logic [5:0] a, input logic [31:0] w);
    sys_addr  = {26'd0, a};
    sys_wdata = w;
    sys_wen   = 1'b1;
    case (a)  // model follows the register write
      scope_pkg::ADR_AVG: m_avg = w[0];
      scope_pkg::ADR_DEC: m_dec = w[16:0];
      scope_pkg::ADR_SHR: m_shr = w[3:0];
      scope_pkg::ADR_LVL: m_lvl = sext14(w);
      scope_pkg::ADR_HST: m_hst = sext14(w);
      scope_pkg::ADR_CTL: begin
        if (w[0]) begin
          m_cnt = 0;
          m_on  = 0;
          m_trg = 0;
          q_dat.delete();
          q_lst.delete();
        end else if (w[2]) begin
          m_on  = 1;
          m_trg = 0;
        end
      end
      default: ;
    endcase
    @(negedge clk);
    sys_wen = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input logic [5:0] a, output logic [31:0] r, output logic e);
    sys_addr = {26'd0, a};
    sys_ren  = 1'b1;
    @(negedge clk);
    sys_ren = 1'b0;
    wait_ack();
    r = sys_rdata;
    e = sys_err;
  endtask

  task automatic expect_reg(input logic [5:0] a, input logic [31:0] exp);
    logic [31:0] r;
    logic        e;
    bus_read(a, r, e);
    if (r !== exp) fail_val($sformatf("sys_rdata[%h]", a), r, exp);
    if (e !== 1'b0) fail_val("sys_err", e, 0);
  endtask

  task automatic send_sample(input logic [13:0] x);
    int start;
    int t;
    start = n_acc;
    t = 0;
    repeat ($urandom % 3) @(negedge clk);  // random idle gap
    sti_dat = x;
    sti_vld = 1'b1;
    while (n_acc == start && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (n_acc == start) timed_out("input ready");
    sti_vld = 1'b0;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while ((q_dat.size() != 0 || sto_vld) && t < 3000) begin
      @(negedge clk);
      t++;
    end
    if (q_dat.size() != 0) timed_out("expected output samples");
    repeat (4) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] w, r;
    logic        e;
    int          lv;
    void'($urandom(32'h5b2f));
    rstn      = 0;
    sti_dat   = '0;
    sti_vld   = 0;
    sto_rdy   = 1;
    rdy_mode  = 0;
    trg_ext   = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 0;
    sys_ren   = 0;
    repeat (10) @(negedge clk);
    rstn = 1;
    @(negedge clk);
    if ({sys_ack, sys_err, sto_vld, sto_lst, trg_out, trg_swo} !== 7'd0)
      fail_val("outputs after reset", {sys_ack, sys_err, sto_vld, sto_lst, trg_out, trg_swo}, 0);
    // register readback
    for (int a = 0; a <= 'h24; a += 4) if (a != 4) expect_reg(a, 0);
    repeat (3) begin
      w = $urandom;
      bus_write(scope_pkg::ADR_AVG, w);
      expect_reg(scope_pkg::ADR_AVG, w & 1);
      w = $urandom;
      bus_write(scope_pkg::ADR_DEC, w);
      expect_reg(scope_pkg::ADR_DEC, w & 'h1ffff);
      w = $urandom;
      bus_write(scope_pkg::ADR_SHR, w);
      expect_reg(scope_pkg::ADR_SHR, w & 'hf);
      w = $urandom;
      bus_write(scope_pkg::ADR_LVL, w);
      expect_reg(scope_pkg::ADR_LVL, sext14(w));
      w = $urandom;
      bus_write(scope_pkg::ADR_HST, w);
      expect_reg(scope_pkg::ADR_HST, sext14(w));
      w = $urandom;
      bus_write(scope_pkg::ADR_SEL, w);
      expect_reg(scope_pkg::ADR_SEL, w & 3);
      w = $urandom;
      bus_write(scope_pkg::ADR_DLY, w);
      expect_reg(scope_pkg::ADR_DLY, w);
    end
    bus_read(6'h04, r, e);  // hole in the map
    if (e !== 1'b1) fail_val("sys_err", e, 1);
    if (r !== 0) fail_val("sys_rdata", r, 0);
    bus_write(scope_pkg::ADR_LVL, 14'h2000);  // park edge level at minimum
    bus_write(scope_pkg::ADR_HST, 0);
    // decimation, then averaging under back-pressure, window held open
    trg_ext = 4'b0001;
    bus_write(scope_pkg::ADR_SEL, 0);
    bus_write(scope_pkg::ADR_DLY, 1000);
    for (int k = 0; k < 8; k++) begin
      rdy_mode = (k < 4) ? 0 : 1;
      bus_write(scope_pkg::ADR_CTL, 1);
      bus_write(scope_pkg::ADR_AVG, k >= 4);
      bus_write(scope_pkg::ADR_DEC, $urandom % 9);
      bus_write(scope_pkg::ADR_SHR, $urandom % 4);
      bus_write(scope_pkg::ADR_CTL, 4);
      repeat (40) send_sample($urandom);
      drain();
    end
    // acquisition window on line 2
    trg_ext = 0;
    rdy_mode = 1;
    bus_write(scope_pkg::ADR_CTL, 1);
    bus_write(scope_pkg::ADR_AVG, 0);
    bus_write(scope_pkg::ADR_DEC, 1);
    bus_write(scope_pkg::ADR_SEL, 2);
    for (int k = 0; k < 4; k++) begin
      w = $urandom % 5;
      bus_write(scope_pkg::ADR_DLY, w);
      bus_write(scope_pkg::ADR_CTL, 4);
      trg_ext[2] = 1'b1;
      m_trg  = 1;
      m_left = w;
      @(negedge clk);
      trg_ext[2] = 1'b0;
      expect_reg(scope_pkg::ADR_CTL, 6);  // armed and triggered
      expect_reg(scope_pkg::ADR_CNT, w);  // full delay loaded
      repeat (w + 6) send_sample($urandom);
      drain();
      expect_reg(scope_pkg::ADR_CTL, 0);
    end
    trg_ext[2] = 1'b1;  // trigger with nothing armed
    @(negedge clk);
    trg_ext[2] = 1'b0;
    repeat (5) send_sample($urandom);
    drain();
    // edge detector, ramps then noise inside the band
    rdy_mode = 0;
    lv = int'($urandom % 2001) - 1000;
    bus_write(scope_pkg::ADR_LVL, lv);
    bus_write(scope_pkg::ADR_HST, 1 + $urandom % 200);
    repeat (2) begin
      p_cnt = 0;
      n_cnt = 0;
      for (int x = lv - m_hst - 300; x <= lv + m_hst + 300; x += 37) send_sample(x);
      for (int x = lv + m_hst + 300; x >= lv - m_hst - 300; x -= 37) send_sample(x);
      repeat (3) @(negedge clk);
      if (p_cnt == 0 || n_cnt == 0) begin
        $display("ramp across the level gave no edge pulse");
        misc_errs++;
      end
    end
    send_sample(lv);  // rising detector fires, both now disarmed
    repeat (3) @(negedge clk);
    p_cnt = 0;
    n_cnt = 0;
    repeat (60) send_sample(lv - m_hst + int'($urandom % (2 * m_hst + 1)));  // inside the band
    repeat (3) @(negedge clk);
    if (p_cnt + n_cnt != 0) begin
      $display("edge pulse from noise inside the hysteresis band");
      misc_errs++;
    end
    // clear during acquisition, software trigger
    trg_ext = 4'b0100;
    bus_write(scope_pkg::ADR_DLY, 50);
    bus_write(scope_pkg::ADR_CTL, 4);
    rdy_mode = 2;
    repeat (2) send_sample($urandom);
    expect_reg(scope_pkg::ADR_CTL, 6);  // running before the clear
    bus_write(scope_pkg::ADR_CTL, 1);
    rdy_mode = 0;
    repeat (10) @(negedge clk);
    expect_reg(scope_pkg::ADR_CTL, 0);
    swo_cnt = 0;
    bus_write(scope_pkg::ADR_CTL, 2);
    repeat (3) @(negedge clk);
    if (swo_cnt != 1) fail_val("trg_swo cycles", swo_cnt, 1);
    finish_run();
  end

endmodule : tb_scope_top

`default_nettype wire

// ==== scope_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module scope_top #(
  parameter int unsigned DWI = 14,          // sample width
  parameter int unsigned TWA = 4,           // ext trigger lines
  parameter int unsigned TWS = $clog2(TWA)  // trigger select width
) (
  input  logic                  clk,
  input  logic                  rstn,
  // stream in
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  output logic                  sti_rdy,
  // stream out
  output logic signed [DWI-1:0] sto_dat,
  output logic                  sto_lst,
  output logic                  sto_vld,
  input  logic                  sto_rdy,
  // triggers
  input  logic        [TWA-1:0] trg_ext,
  output logic                  trg_swo,  // software trigger pulse
  output logic            [1:0] trg_out,  // 0 pos edge, 1 neg edge
  // system bus
  input  logic           [31:0] sys_addr,
  input  logic           [31:0] sys_wdata,
  input  logic                  sys_wen,
  input  logic                  sys_ren,
  output logic           [31:0] sys_rdata,
  output logic                  sys_ack,
  output logic                  sys_err
);

  scope_pkg::scope_ctl_t     ctl;
  scope_pkg::scope_dec_cfg_t dec_cfg;
  scope_pkg::scope_sts_t     sts;
  logic signed     [DWI-1:0] lvl;
  logic signed     [DWI-1:0] hst;
  logic            [TWS-1:0] sel;
  logic               [31:0] dly;
  logic signed     [DWI-1:0] std_dat;  // decimated stream
  logic                      std_vld;
  logic                      std_rdy;
  logic                      trg_mux;  // selected ext line

  assign trg_mux = trg_ext[sel];
  assign trg_swo = ctl.swt;

  ////////////////////////////////////////////////////////////////////////////
  // blocks
  ////////////////////////////////////////////////////////////////////////////

  scope_regs #(.DWI(DWI), .TWS(TWS)) regs_inst (
    .clk(clk), .rstn(rstn),
    .sys_addr(sys_addr), .sys_wdata(sys_wdata),
    .sys_wen(sys_wen), .sys_ren(sys_ren),
    .sys_rdata(sys_rdata), .sys_ack(sys_ack), .sys_err(sys_err),
    .sts(sts), .ctl(ctl), .dec_cfg(dec_cfg),
    .lvl(lvl), .hst(hst), .sel(sel), .dly(dly)
  );

  scope_dec_avg #(.DWI(DWI)) dec_avg_inst (
    .clk(clk), .rstn(rstn),
    .clr(ctl.clr), .cfg(dec_cfg),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .sto_dat(std_dat), .sto_vld(std_vld), .sto_rdy(std_rdy)
  );

  // watches the raw input, does not touch the handshake
  scope_edge #(.DWI(DWI)) edge_inst (
    .clk(clk), .rstn(rstn),
    .sti_dat(sti_dat), .sti_vld(sti_vld), .sti_rdy(sti_rdy),
    .lvl(lvl), .hst(hst),
    .trg_pdg(trg_out[0]), .trg_ndg(trg_out[1])
  );

  scope_acq #(.DWI(DWI)) acq_inst (
    .clk(clk), .rstn(rstn),
    .ctl(ctl), .dly(dly), .trg(trg_mux),
    .std_dat(std_dat), .std_vld(std_vld), .std_rdy(std_rdy),
    .sts(sts),
    .sto_dat(sto_dat), .sto_lst(sto_lst), .sto_vld(sto_vld), .sto_rdy(sto_rdy)
  );

endmodule : scope_top

`default_nettype wire

// ==== scope_acq.sv ====
`default_nettype none
`timescale 1ns/1ps

module scope_acq #(
  parameter int unsigned DWI = 14  // sample width
) (
  input  logic                  clk,
  input  logic                  rstn,
  // control
  input  scope_pkg::scope_ctl_t ctl,
  input  logic           [31:0] dly,
  input  logic                  trg,
  // stream from decimator
  input  logic signed [DWI-1:0] std_dat,
  input  logic                  std_vld,
  output logic                  std_rdy,
  // status
  output scope_pkg::scope_sts_t sts,
  // stream out
  output logic signed [DWI-1:0] sto_dat,
  output logic                  sto_lst,
  output logic                  sto_vld,
  input  logic                  sto_rdy
);

  logic        acq;    // armed
  logic        trg_q;  // trigger seen
  logic [31:0] cnt;    // samples left after trigger, minus one
  logic        dlv;    // sample moves into the output register
  logic        fin;    // delivered sample is the last one

  // idle: swallow decimator output
  assign std_rdy = ~acq | ~sto_vld | sto_rdy;
  assign dlv     = acq & std_vld & std_rdy;
  assign fin     = dlv & trg_q & (cnt == '0);

  assign sts = '{acq: acq, trg: trg_q, cnt: cnt};

  ////////////////////////////////////////////////////////////////////////////
  // arm / trigger / delay sequence
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acq   <= 1'b0;
      trg_q <= 1'b0;
      cnt   <= '0;
    end else if (ctl.clr) begin
      acq   <= 1'b0;
      trg_q <= 1'b0;
    end else begin
      if (fin) begin
        acq   <= 1'b0;           // window closed
        trg_q <= 1'b0;
      end else if (acq && !trg_q && trg) begin
        trg_q <= 1'b1;
        cnt   <= dly;            // dly+1 samples follow
      end else if (dlv && trg_q) begin
        cnt   <= cnt - 1'b1;
      end
      if (ctl.arm) begin
        acq   <= 1'b1;           // rearm wins over close
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else if (ctl.clr) begin
      sto_vld <= 1'b0;           // flush
      sto_lst <= 1'b0;
    end else if (dlv) begin
      sto_vld <= 1'b1;
      sto_lst <= fin;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dlv) begin
      sto_dat <= std_dat;
    end
  end

  // last marker only rides on a valid beat
  assert property (@(posedge clk) disable iff (!rstn) sto_lst |-> sto_vld)
    else $error("scope_acq: sto_lst without sto_vld");

endmodule : scope_acq

`default_nettype wire

// ==== scope_edge.sv ====
`default_nettype none
`timescale 1ns/1ps

module scope_edge #(
  parameter int unsigned DWI = 14  // sample width
) (
  input  logic                  clk,
  input  logic                  rstn,
  // monitored stream
  input  logic signed [DWI-1:0] sti_dat,
  input  logic                  sti_vld,
  input  logic                  sti_rdy,
  // threshold
  input  logic signed [DWI-1:0] lvl,
  input  logic signed [DWI-1:0] hst,
  // edge pulses
  output logic                  trg_pdg,
  output logic                  trg_ndg
);

  logic signed [DWI:0] lvl_lo;  // positive arming threshold, one extra bit
  logic signed [DWI:0] lvl_hi;  // negative arming threshold
  logic                acc;     // sample seen on the stream
  logic                arm_p;   // waiting for rising crossing
  logic                arm_n;   // waiting for falling crossing

  assign lvl_lo = lvl - hst;
  assign lvl_hi = lvl + hst;
  assign acc    = sti_vld & sti_rdy;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arm_p   <= 1'b0;
      arm_n   <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= 1'b0;  // single cycle pulses
      trg_ndg <= 1'b0;
      if (acc) begin
        // rising
        if (arm_p && (sti_dat >= lvl)) begin
          trg_pdg <= 1'b1;
          arm_p   <= 1'b0;  // disarm on fire
        end else if (sti_dat < lvl_lo) begin
          arm_p   <= 1'b1;
        end
        // falling, mirror image
        if (arm_n && (sti_dat <= lvl)) begin
          trg_ndg <= 1'b1;
          arm_n   <= 1'b0;
        end else if (sti_dat > lvl_hi) begin
          arm_n   <= 1'b1;
        end
      end
    end
  end

endmodule : scope_edge

`default_nettype wire

// ==== scope_dec_avg.sv ====
`default_nettype none
`timescale 1ns/1ps

module scope_dec_avg #(
  parameter int unsigned DWI = 14  // sample width
) (
  input  logic                      clk,
  input  logic                      rstn,
  // control / config
  input  logic                      clr,
  input  scope_pkg::scope_dec_cfg_t cfg,
  // stream in
  input  logic signed     [DWI-1:0] sti_dat,
  input  logic                      sti_vld,
  output logic                      sti_rdy,
  // stream out
  output logic signed     [DWI-1:0] sto_dat,
  output logic                      sto_vld,
  input  logic                      sto_rdy
);

  localparam int unsigned SUM_W = DWI + scope_pkg::DEC_W;  // no overflow over a group

  logic [scope_pkg::DEC_W-1:0] cnt;      // samples taken in this group
  logic signed     [SUM_W-1:0] sum;      // running group sum
  logic signed     [SUM_W-1:0] sum_nxt;  // sum including current sample
  logic signed     [SUM_W-1:0] sum_shr;  // scaled sum
  logic                        acc;      // input transfer
  logic                        lst;      // current sample closes the group

  // no bubble: refill in the same cycle the output is taken
  assign sti_rdy = ~sto_vld | sto_rdy;
  assign acc     = sti_vld & sti_rdy;

  // dec of 0 or 1 passes every sample
  assign lst = (cfg.dec <= 1) || (cnt >= cfg.dec - 1'b1);

  always_comb begin
    sum_nxt = sti_dat;              // first sample of the group
    if (cnt != '0) begin
      sum_nxt = sum + sti_dat;
    end
    sum_shr = sum_nxt >>> cfg.shr;  // arithmetic, keeps the sign
  end

  ////////////////////////////////////////////////////////////////////////////
  // group counter and accumulator
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else if (clr) begin
      cnt <= '0;                     // restart group
    end else if (acc) begin
      cnt <= lst ? '0 : cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      sum <= sum_nxt;  // only read while cnt != 0
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sto_vld <= 1'b0;
    end else if (clr) begin
      sto_vld <= 1'b0;               // drop pending result
    end else if (acc && lst) begin
      sto_vld <= 1'b1;
    end else if (sto_rdy) begin
      sto_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (acc && lst) begin
      sto_dat <= cfg.avg ? sum_shr[DWI-1:0] : sti_dat;  // truncated average or last
    end
  end

  // held output must not change until taken
  assert property (@(posedge clk) disable iff (!rstn)
    sto_vld && !sto_rdy && !clr |=> sto_vld && $stable(sto_dat))
    else $error("scope_dec_avg: output changed under back-pressure");

endmodule : scope_dec_avg

`default_nettype wire

// ==== scope_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module scope_regs #(
  parameter int unsigned DWI = 14,  // sample width
  parameter int unsigned TWS = 2    // trigger select width
) (
  input  logic                              clk,
  input  logic                              rstn,
  // system bus
  input  logic                       [31:0] sys_addr,
  input  logic                       [31:0] sys_wdata,
  input  logic                              sys_wen,
  input  logic                              sys_ren,
  output logic                       [31:0] sys_rdata,
  output logic                              sys_ack,
  output logic                              sys_err,
  // status in
  input  scope_pkg::scope_sts_t             sts,
  // control / config out
  output scope_pkg::scope_ctl_t             ctl,
  output scope_pkg::scope_dec_cfg_t         dec_cfg,
  output logic signed             [DWI-1:0] lvl,
  output logic signed             [DWI-1:0] hst,
  output logic                    [TWS-1:0] sel,
  output logic                       [31:0] dly
);

  logic  [5:0] adr;     // word offset within the block
  logic [31:0] rd_val;  // read mux
  logic        rd_hit;  // address is in the map

  assign adr = sys_addr[5:0];

  // strobes live only in the write cycle
  assign ctl.clr = sys_wen & (adr == scope_pkg::ADR_CTL) & sys_wdata[0];
  assign ctl.swt = sys_wen & (adr == scope_pkg::ADR_CTL) & sys_wdata[1];
  assign ctl.arm = sys_wen & (adr == scope_pkg::ADR_CTL) & sys_wdata[2];

  ////////////////////////////////////////////////////////////////////////////
  // config registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dec_cfg <= '0;
      lvl     <= '0;
      hst     <= '0;
      sel     <= '0;
      dly     <= '0;
    end else if (sys_wen) begin
      case (adr)
        scope_pkg::ADR_AVG: dec_cfg.avg <= sys_wdata[0];
        scope_pkg::ADR_DEC: dec_cfg.dec <= sys_wdata[scope_pkg::DEC_W-1:0];
        scope_pkg::ADR_SHR: dec_cfg.shr <= sys_wdata[scope_pkg::SHR_W-1:0];
        scope_pkg::ADR_LVL: lvl <= sys_wdata[DWI-1:0];  // upper bits dropped
        scope_pkg::ADR_HST: hst <= sys_wdata[DWI-1:0];
        scope_pkg::ADR_SEL: sel <= sys_wdata[TWS-1:0];
        scope_pkg::ADR_DLY: dly <= sys_wdata;
        default: ;  // ctl, cnt and holes hold nothing
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux and bus response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_val = '0;
    rd_hit = 1'b1;
    case (adr)
      scope_pkg::ADR_CTL: rd_val = {29'd0, sts.acq, sts.trg, 1'b0};
      scope_pkg::ADR_AVG: rd_val = {31'd0, dec_cfg.avg};
      scope_pkg::ADR_DEC: rd_val = {{(32-scope_pkg::DEC_W){1'b0}}, dec_cfg.dec};
      scope_pkg::ADR_SHR: rd_val = {{(32-scope_pkg::SHR_W){1'b0}}, dec_cfg.shr};
      scope_pkg::ADR_LVL: rd_val = {{(32-DWI){lvl[DWI-1]}}, lvl};  // sign ext
      scope_pkg::ADR_HST: rd_val = {{(32-DWI){hst[DWI-1]}}, hst};
      scope_pkg::ADR_SEL: rd_val = {{(32-TWS){1'b0}}, sel};
      scope_pkg::ADR_DLY: rd_val = dly;
      scope_pkg::ADR_CNT: rd_val = sts.cnt;
      default:            rd_hit = 1'b0;  // hole, reads zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_ren) begin
      sys_rdata <= rd_val;  // lines up with ack
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_ack <= 1'b0;
      sys_err <= 1'b0;
    end else begin
      sys_ack <= sys_wen | sys_ren;                // one cycle later
      sys_err <= (sys_wen | sys_ren) & ~rd_hit;    // unmapped access
    end
  end

  // a bus master issues one kind of access per cycle
  assert property (@(posedge clk) disable iff (!rstn) !(sys_wen && sys_ren))
    else $error("scope_regs: read and write in the same cycle");

endmodule : scope_regs

`default_nettype wire

// ==== scope_pkg.sv ====
`default_nettype none

package scope_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // fixed widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DEC_W = 17;  // decimation factor / group counter
  localparam int unsigned SHR_W = 4;   // averaging right shift

  ////////////////////////////////////////////////////////////////////////////
  // register map, low 6 address bits
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [5:0] ADR_CTL = 6'h00;  // wr strobes, rd status
  localparam logic [5:0] ADR_AVG = 6'h08;  // averaging enable
  localparam logic [5:0] ADR_DEC = 6'h0C;  // decimation factor
  localparam logic [5:0] ADR_SHR = 6'h10;  // sum shift right
  localparam logic [5:0] ADR_LVL = 6'h14;  // edge level
  localparam logic [5:0] ADR_HST = 6'h18;  // edge hysteresis
  localparam logic [5:0] ADR_SEL = 6'h1C;  // ext trigger select
  localparam logic [5:0] ADR_DLY = 6'h20;  // post trigger delay
  localparam logic [5:0] ADR_CNT = 6'h24;  // remaining delay, ro

  // single cycle strobes, bit order matches wdata[2:0]
  typedef struct packed {
    logic arm;  // bit 2, start acquisition
    logic swt;  // bit 1, software trigger out
    logic clr;  // bit 0, clear acquisition
  } scope_ctl_t;

  // decimator setup
  typedef struct packed {
    logic             avg;  // output group average instead of last sample
    logic [DEC_W-1:0] dec;  // group length, 0/1 pass all
    logic [SHR_W-1:0] shr;  // arithmetic shift of the group sum
  } scope_dec_cfg_t;

  // acquisition status back to the bus
  typedef struct packed {
    logic        acq;  // armed / acquiring
    logic        trg;  // trigger seen
    logic [31:0] cnt;  // samples left after trigger, minus one
  } scope_sts_t;

endpackage : scope_pkg

`default_nettype wire
